// ==== hw/noc_pkg.sv ====
/*
 * NoC package for the mesh node router.
 * Holds the mesh coordinate and port definitions, the flit header and
 * the flit formats of the request, response and wide networks.
 */

package noc_pkg;

  // Mesh geometry, 4 by 4 nodes
  localparam int unsigned CoordWidth = 2;

  // Router ports
  localparam int unsigned NumPorts  = 5;
  localparam int unsigned PortLocal = 0;
  localparam int unsigned PortNorth = 1;
  localparam int unsigned PortEast  = 2;
  localparam int unsigned PortSouth = 3;
  localparam int unsigned PortWest  = 4;

  // Entries per input FIFO
  localparam int unsigned InFifoDepth = 2;

  typedef logic [CoordWidth-1:0] coord_t;

  typedef struct packed {
    coord_t dst_x;
    coord_t dst_y;
  } hdr_t;

  // All flit formats lead with the header under the same field name
  typedef struct packed {
    hdr_t        hdr;
    logic [31:0] data;
  } req_flit_t;

  typedef struct packed {
    hdr_t       hdr;
    logic [1:0] resp;
    logic [7:0] tag;
  } rsp_flit_t;

  typedef struct packed {
    hdr_t        hdr;
    logic [63:0] data;
  } wide_flit_t;

endpackage

// ==== hw/flit_fifo.sv ====
/*
 * Flit FIFO, a small register array with valid/ready on both sides.
 * Accepts a push in the same cycle as a pop even when full.
 */

`timescale 1ns/1ps

module flit_fifo #(
  parameter type         flit_t = noc_pkg::req_flit_t,
  parameter int unsigned Depth  = noc_pkg::InFifoDepth
) (
  input  logic  clk_i,
  input  logic  arst_n_i,
  input  logic  valid_i,
  output logic  ready_o,
  input  flit_t data_i,
  output logic  valid_o,
  input  logic  ready_i,
  output flit_t data_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  flit_t               mem_q [Depth];
  logic [PtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                full, push, pop;

  assign full    = (count_q == CntWidth'(Depth));
  assign valid_o = (count_q != '0);
  assign pop     = valid_o & ready_i;
  // A pop frees the slot the push needs
  assign ready_o = ~full | pop;
  assign push    = valid_i & ready_o;
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

// ==== hw/rr_arbiter.sv ====
/*
 * Round-robin arbiter over the five router inputs.
 * Holds its grant until the granted flit is taken.
 */

`timescale 1ns/1ps

module rr_arbiter (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic [noc_pkg::NumPorts-1:0] req_i,
  input  logic                        ack_i,
  output logic [noc_pkg::NumPorts-1:0] gnt_o,
  output logic                        valid_o
);

  localparam int unsigned NumReq   = noc_pkg::NumPorts;
  localparam int unsigned IdxWidth = $clog2(NumReq);

  logic [IdxWidth-1:0] ptr_q, gnt_idx_q, pick_idx, sel_idx;
  logic                lock_q, pick_vld;

  // First requester at or after the pointer
  always_comb begin
    int unsigned cand;
    pick_vld = 1'b0;
    pick_idx = ptr_q;
    for (int unsigned i = 0; i < NumReq; i++) begin
      cand = (ptr_q + i) % NumReq;
      if (!pick_vld && req_i[cand]) begin
        pick_vld = 1'b1;
        pick_idx = IdxWidth'(cand);
      end
    end
  end

  // A stalled grant stays put so the switched data stays stable
  assign sel_idx = lock_q ? gnt_idx_q : pick_idx;
  assign valid_o = lock_q | pick_vld;
  assign gnt_o   = valid_o ? (NumReq'(1) << sel_idx) : '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptr_q     <= '0;
      gnt_idx_q <= '0;
      lock_q    <= 1'b0;
    end else if (valid_o) begin
      if (ack_i) begin
        lock_q <= 1'b0;
        ptr_q  <= (sel_idx == IdxWidth'(NumReq - 1)) ? '0 : sel_idx + 1'b1;
      end else begin
        lock_q    <= 1'b1;
        gnt_idx_q <= sel_idx;
      end
    end
  end

endmodule

// ==== hw/mesh_router.sv ====
/*
 * Generic five-port mesh router with XY routing.
 * Input FIFOs feed a route stage, one round-robin arbiter per output
 * selects which FIFO head is switched onto that output.
 */

`timescale 1ns/1ps

module mesh_router #(
  parameter type flit_t = noc_pkg::req_flit_t
) (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  input  noc_pkg::coord_t              id_x_i,
  input  noc_pkg::coord_t              id_y_i,
  input  logic  [noc_pkg::NumPorts-1:0] valid_i,
  output logic  [noc_pkg::NumPorts-1:0] ready_o,
  input  flit_t [noc_pkg::NumPorts-1:0] data_i,
  output logic  [noc_pkg::NumPorts-1:0] valid_o,
  input  logic  [noc_pkg::NumPorts-1:0] ready_i,
  output flit_t [noc_pkg::NumPorts-1:0] data_o
);

  localparam int unsigned NumPorts = noc_pkg::NumPorts;

  // FIFO heads
  logic  [NumPorts-1:0] head_valid;
  flit_t [NumPorts-1:0] head_flit;
  logic  [NumPorts-1:0] pop;

  // route_req[in][out] and its transpose out_req[out][in]
  logic [NumPorts-1:0][NumPorts-1:0] route_req;
  logic [NumPorts-1:0][NumPorts-1:0] out_req;
  logic [NumPorts-1:0][NumPorts-1:0] gnt;

  // Completed transfer per output
  logic [NumPorts-1:0] out_ack;

  for (genvar i = 0; i < NumPorts; i++) begin : gen_input
    logic [NumPorts-1:0] route;

    flit_fifo #(
      .flit_t ( flit_t               ),
      .Depth  ( noc_pkg::InFifoDepth )
    ) u_in_fifo (
      .clk_i,
      .arst_n_i,
      .valid_i ( valid_i[i]    ),
      .ready_o ( ready_o[i]    ),
      .data_i  ( data_i[i]     ),
      .valid_o ( head_valid[i] ),
      .ready_i ( pop[i]        ),
      .data_o  ( head_flit[i]  )
    );

    // Dimension order, X first then Y
    always_comb begin
      route = '0;
      if (head_valid[i]) begin
        if (head_flit[i].hdr.dst_x > id_x_i) begin
          route[noc_pkg::PortEast] = 1'b1;
        end else if (head_flit[i].hdr.dst_x < id_x_i) begin
          route[noc_pkg::PortWest] = 1'b1;
        end else if (head_flit[i].hdr.dst_y > id_y_i) begin
          route[noc_pkg::PortNorth] = 1'b1;
        end else if (head_flit[i].hdr.dst_y < id_y_i) begin
          route[noc_pkg::PortSouth] = 1'b1;
        end else begin
          route[noc_pkg::PortLocal] = 1'b1;
        end
      end
    end

    assign route_req[i] = route;
  end

  always_comb begin
    for (int unsigned o = 0; o < NumPorts; o++) begin
      for (int unsigned i = 0; i < NumPorts; i++) begin
        out_req[o][i] = route_req[i][o];
      end
    end
  end

  for (genvar o = 0; o < NumPorts; o++) begin : gen_output
    flit_t out_flit;
    logic  out_valid;

    rr_arbiter u_arb (
      .clk_i,
      .arst_n_i,
      .req_i   ( out_req[o] ),
      .ack_i   ( out_ack[o] ),
      .gnt_o   ( gnt[o]     ),
      .valid_o ( out_valid  )
    );

    // Switch the granted head onto the output
    always_comb begin
      out_flit = '0;
      for (int unsigned i = 0; i < NumPorts; i++) begin
        if (gnt[o][i]) begin
          out_flit = head_flit[i];
        end
      end
    end

    assign valid_o[o] = out_valid;
    assign data_o[o]  = out_flit;
    assign out_ack[o] = out_valid & ready_i[o];
  end

  // Each head requests one output only, so at most one term is set
  always_comb begin
    for (int unsigned i = 0; i < NumPorts; i++) begin
      pop[i] = 1'b0;
      for (int unsigned o = 0; o < NumPorts; o++) begin
        pop[i] = pop[i] | (gnt[o][i] & out_ack[o]);
      end
    end
  end

endmodule

// ==== hw/nw_router.sv ====
/*
 * Mesh node with three independent physical networks.
 * Narrow request, response and wide traffic each pass through their own
 * instance of the generic XY router.
 */

`timescale 1ns/1ps

module nw_router (
  input  logic                                         clk_i,
  input  logic                                         arst_n_i,
  input  noc_pkg::coord_t                              id_x_i,
  input  noc_pkg::coord_t                              id_y_i,
  // Narrow request network
  input  logic                [noc_pkg::NumPorts-1:0] req_valid_i,
  output logic                [noc_pkg::NumPorts-1:0] req_ready_o,
  input  noc_pkg::req_flit_t  [noc_pkg::NumPorts-1:0] req_data_i,
  output logic                [noc_pkg::NumPorts-1:0] req_valid_o,
  input  logic                [noc_pkg::NumPorts-1:0] req_ready_i,
  output noc_pkg::req_flit_t  [noc_pkg::NumPorts-1:0] req_data_o,
  // Response network
  input  logic                [noc_pkg::NumPorts-1:0] rsp_valid_i,
  output logic                [noc_pkg::NumPorts-1:0] rsp_ready_o,
  input  noc_pkg::rsp_flit_t  [noc_pkg::NumPorts-1:0] rsp_data_i,
  output logic                [noc_pkg::NumPorts-1:0] rsp_valid_o,
  input  logic                [noc_pkg::NumPorts-1:0] rsp_ready_i,
  output noc_pkg::rsp_flit_t  [noc_pkg::NumPorts-1:0] rsp_data_o,
  // Wide network
  input  logic                [noc_pkg::NumPorts-1:0] wide_valid_i,
  output logic                [noc_pkg::NumPorts-1:0] wide_ready_o,
  input  noc_pkg::wide_flit_t [noc_pkg::NumPorts-1:0] wide_data_i,
  output logic                [noc_pkg::NumPorts-1:0] wide_valid_o,
  input  logic                [noc_pkg::NumPorts-1:0] wide_ready_i,
  output noc_pkg::wide_flit_t [noc_pkg::NumPorts-1:0] wide_data_o
);

  mesh_router #(
    .flit_t ( noc_pkg::req_flit_t )
  ) u_req_router (
    .clk_i,
    .arst_n_i,
    .id_x_i,
    .id_y_i,
    .valid_i ( req_valid_i ),
    .ready_o ( req_ready_o ),
    .data_i  ( req_data_i  ),
    .valid_o ( req_valid_o ),
    .ready_i ( req_ready_i ),
    .data_o  ( req_data_o  )
  );

  mesh_router #(
    .flit_t ( noc_pkg::rsp_flit_t )
  ) u_rsp_router (
    .clk_i,
    .arst_n_i,
    .id_x_i,
    .id_y_i,
    .valid_i ( rsp_valid_i ),
    .ready_o ( rsp_ready_o ),
    .data_i  ( rsp_data_i  ),
    .valid_o ( rsp_valid_o ),
    .ready_i ( rsp_ready_i ),
    .data_o  ( rsp_data_o  )
  );

  // Wide links stall on their own, the other networks keep moving
  mesh_router #(
    .flit_t ( noc_pkg::wide_flit_t )
  ) u_wide_router (
    .clk_i,
    .arst_n_i,
    .id_x_i,
    .id_y_i,
    .valid_i ( wide_valid_i ),
    .ready_o ( wide_ready_o ),
    .data_i  ( wide_data_i  ),
    .valid_o ( wide_valid_o ),
    .ready_i ( wide_ready_i ),
    .data_o  ( wide_data_o  )
  );

endmodule

// ==== dv/tb_nw_router.sv ====
/*
 * Testbench for the three-network mesh node router.
 * Replays the vector file on all links, applies random and scripted
 * back-pressure, and checks routing, order, arbitration and stall behavior.
 */

`timescale 1ns/1ps

module tb_nw_router;

  localparam int NumPorts = noc_pkg::NumPorts;
  localparam int NodeX    = 1;
  localparam int NodeY    = 2;
  localparam int MaxVec   = 128;

  logic clk_i, arst_n_i;
  logic [NumPorts-1:0] in_valid [3], in_ready [3], out_valid [3], out_ready [3];
  logic [67:0] in_data [3][NumPorts];
  logic [67:0] out_data [3][NumPorts];

  noc_pkg::req_flit_t  [NumPorts-1:0] req_data_i, req_data_o;
  noc_pkg::rsp_flit_t  [NumPorts-1:0] rsp_data_i, rsp_data_o;
  noc_pkg::wide_flit_t [NumPorts-1:0] wide_data_i, wide_data_o;

  // Vector store and per-lane issue queues
  int          nvec, seed, cyc, limit;
  int          vec_out [MaxVec];
  int          vec_stall [MaxVec];
  logic [67:0] vec_val [MaxVec];
  int          lane_q [3][NumPorts][$];
  int          cur_vec [3][NumPorts];
  bit          busy [3][NumPorts];
  bit          fired [3][NumPorts];
  int          stall_cnt [3][NumPorts];

  // Expected flits per network, input and output, and per-input send order
  logic [67:0] exp_q [3][NumPorts][NumPorts][$];
  int          ord_q [3][NumPorts][$];
  int          wait_cnt [3][NumPorts][NumPorts];
  bit          held_v [3][NumPorts];
  logic [67:0] held_d [3][NumPorts];

  bit    started, wide_hold, saw_full, timed_out, load_err;
  int    data_errs, proto_errs, indep_cnt;
  string net_name [3] = '{"req", "rsp", "wide"};

  nw_router u_nw_router (
    .clk_i, .arst_n_i,
    .id_x_i       ( noc_pkg::coord_t'(NodeX) ),
    .id_y_i       ( noc_pkg::coord_t'(NodeY) ),
    .req_valid_i  ( in_valid[0]  ), .req_ready_o  ( in_ready[0]  ), .req_data_i  ( req_data_i  ),
    .req_valid_o  ( out_valid[0] ), .req_ready_i  ( out_ready[0] ), .req_data_o  ( req_data_o  ),
    .rsp_valid_i  ( in_valid[1]  ), .rsp_ready_o  ( in_ready[1]  ), .rsp_data_i  ( rsp_data_i  ),
    .rsp_valid_o  ( out_valid[1] ), .rsp_ready_i  ( out_ready[1] ), .rsp_data_o  ( rsp_data_o  ),
    .wide_valid_i ( in_valid[2]  ), .wide_ready_o ( in_ready[2]  ), .wide_data_i ( wide_data_i ),
    .wide_valid_o ( out_valid[2] ), .wide_ready_i ( out_ready[2] ), .wide_data_o ( wide_data_o )
  );

  for (genvar p = 0; p < NumPorts; p++) begin : gen_link
    assign req_data_i[p]  = in_data[0][p][35:0];
    assign rsp_data_i[p]  = in_data[1][p][13:0];
    assign wide_data_i[p] = in_data[2][p];
    assign out_data[0][p] = 68'(req_data_o[p]);
    assign out_data[1][p] = 68'(rsp_data_o[p]);
    assign out_data[2][p] = 68'(wide_data_o[p]);
  end

  always #10 clk_i = ~clk_i;

  // Expected output port by XY dimension order
  function automatic int xy_port(input int dx, input int dy);
    if (dx > NodeX) return noc_pkg::PortEast;
    if (dx < NodeX) return noc_pkg::PortWest;
    if (dy > NodeY) return noc_pkg::PortNorth;
    if (dy < NodeY) return noc_pkg::PortSouth;
    return noc_pkg::PortLocal;
  endfunction

  task automatic load_vectors();
    int          fd, net, port, dx, dy, stall;
    logic [63:0] pay;
    logic [3:0]  hdr;
    string       line;
    fd = $fopen("dv/nw_router_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file dv/nw_router_vectors.txt");
      load_err = 1;
      return;
    end
    while (!$feof(fd) && nvec < MaxVec) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line[0] != "#" &&
          $sscanf(line, "%d %d %d %d %h %d", net, port, dx, dy, pay, stall) == 6) begin
        hdr = {dx[1:0], dy[1:0]};
        case (net)
          0:       vec_val[nvec] = 68'({hdr, pay[31:0]});
          1:       vec_val[nvec] = 68'({hdr, pay[9:0]});
          default: vec_val[nvec] = {hdr, pay};
        endcase
        vec_out[nvec]   = xy_port(dx, dy);
        vec_stall[nvec] = stall;
        lane_q[net][port].push_back(nvec);
        nvec++;
      end
    end
    $fclose(fd);
  endtask

  function automatic bit all_idle();
    for (int n = 0; n < 3; n++) begin
      for (int i = 0; i < NumPorts; i++) begin
        if (busy[n][i] || lane_q[n][i].size() > 0) return 0;
        for (int o = 0; o < NumPorts; o++) begin
          if (exp_q[n][i][o].size() > 0) return 0;
        end
      end
    end
    return 1;
  endfunction

  // Drive inputs and output ready shortly after each rising edge
  always @(posedge clk_i) begin
    #2;
    wide_hold = started && cyc < 60;
    for (int n = 0; n < 3; n++) begin
      for (int p = 0; p < NumPorts; p++) begin
        if (busy[n][p] && fired[n][p]) begin
          busy[n][p] = 0;
        end
        if (started && !busy[n][p] && lane_q[n][p].size() > 0) begin
          cur_vec[n][p] = lane_q[n][p].pop_front();
          busy[n][p]    = 1;
          in_data[n][p] = vec_val[cur_vec[n][p]];
          if (vec_stall[cur_vec[n][p]] > 0) begin
            stall_cnt[n][vec_out[cur_vec[n][p]]] = vec_stall[cur_vec[n][p]];
          end
        end
        in_valid[n][p] = busy[n][p];
      end
      for (int o = 0; o < NumPorts; o++) begin
        if (stall_cnt[n][o] > 0) stall_cnt[n][o]--;
        out_ready[n][o] = (stall_cnt[n][o] == 0) && !(n == 2 && wide_hold) &&
                          (($random(seed) & 7) != 0);
      end
    end
  end

  // Sample handshakes and check outputs in the middle of the cycle
  always @(negedge clk_i) begin
    int          src, v;
    int          head_out [NumPorts];
    logic [67:0] exp;
    for (int n = 0; n < 3; n++) begin
      // Output wanted by each FIFO head in this cycle
      for (int i = 0; i < NumPorts; i++) begin
        head_out[i] = (ord_q[n][i].size() > 0) ? ord_q[n][i][0] : -1;
      end
      if (!started && out_valid[n] != '0) begin
        $display("Output valid on the %s network before stimulus started", net_name[n]);
        proto_errs++;
      end
      for (int p = 0; p < NumPorts; p++) begin
        fired[n][p] = in_valid[n][p] && in_ready[n][p];
        if (in_valid[n][p] && !in_ready[n][p]) saw_full = 1;
        if (fired[n][p]) begin
          v = cur_vec[n][p];
          exp_q[n][p][vec_out[v]].push_back(vec_val[v]);
          ord_q[n][p].push_back(vec_out[v]);
        end
      end
      for (int o = 0; o < NumPorts; o++) begin
        if (held_v[n][o]) begin
          if (!out_valid[n][o]) begin
            $display("ERROR t=%0t %s_valid_o[%0d] expected 1 actual 0", $time, net_name[n], o);
            data_errs++;
          end else if (out_data[n][o] != held_d[n][o]) begin
            $display("ERROR t=%0t %s_data_o[%0d] expected %h actual %h", $time, net_name[n],
                     o, held_d[n][o], out_data[n][o]);
            data_errs++;
          end
        end
        held_v[n][o] = out_valid[n][o] && !out_ready[n][o];
        held_d[n][o] = out_data[n][o];
        if (out_valid[n][o] && out_ready[n][o]) begin
          if (n != 2 && wide_hold) indep_cnt++;
          src = int'(out_data[n][o][2:0]);
          if (src >= NumPorts || exp_q[n][src][o].size() == 0) begin
            $display("Unexpected flit %h on %s output %0d", out_data[n][o], net_name[n], o);
            proto_errs++;
          end else begin
            exp = exp_q[n][src][o].pop_front();
            if (out_data[n][o] != exp) begin
              $display("ERROR t=%0t %s_data_o[%0d] expected %h actual %h", $time, net_name[n],
                       o, exp, out_data[n][o]);
              data_errs++;
            end
            void'(ord_q[n][src].pop_front());
            wait_cnt[n][o][src] = 0;
            // Inputs whose head also wants this output lose one turn
            for (int i = 0; i < NumPorts; i++) begin
              if (i != src && head_out[i] == o) begin
                wait_cnt[n][o][i]++;
                if (wait_cnt[n][o][i] > 4) begin
                  $display("Input %0d did not get a turn within five transfers on %s output %0d",
                           i, net_name[n], o);
                  proto_errs++;
                end
              end
            end
          end
        end
      end
    end
  end

  initial begin
    clk_i    = 1'b0;
    arst_n_i = 1'b0;
    seed     = 80901;
    for (int n = 0; n < 3; n++) begin
      in_valid[n]  = '0;
      out_ready[n] = '1;
      for (int p = 0; p < NumPorts; p++) in_data[n][p] = '0;
    end
    load_vectors();
    limit = 40 * nvec + 200;
    repeat (4) @(posedge clk_i);
    #2;
    arst_n_i = 1'b1;
    repeat (3) @(posedge clk_i);
    started = 1;
    while (!load_err && !(all_idle() && cyc >= 60) && cyc < limit) begin
      @(posedge clk_i);
      cyc++;
    end
    if (cyc >= limit) begin
      timed_out = 1;
      $display("Timeout after %0d cycles with flits still pending", cyc);
      for (int n = 0; n < 3; n++) begin
        for (int i = 0; i < NumPorts; i++) begin
          for (int o = 0; o < NumPorts; o++) begin
            if (exp_q[n][i][o].size() > 0) begin
              $display("Timeout with %0d flits still expected on %s from input %0d to output %0d",
                       exp_q[n][i][o].size(), net_name[n], i, o);
            end
          end
        end
      end
    end
    if (!saw_full) begin
      $display("No input FIFO ever dropped ready under back-pressure");
      proto_errs++;
    end
    if (indep_cnt == 0) begin
      $display("No request or response traffic moved while wide outputs were stalled");
      proto_errs++;
    end
    $display("Errors: data %0d, protocol %0d, timeout %0d, load %0d",
             data_errs, proto_errs, timed_out, load_err);
    if (data_errs == 0 && proto_errs == 0 && !timed_out && !load_err) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== dv/nw_router_vectors.txt ====
# net(0 req,1 rsp,2 wide) in_port dst_x dst_y payload_hex stall_cycles
# payload low 3 bits hold the input port, node sits at (1,2)
0 0 2 2 00000010 0
0 1 0 2 00000011 0
0 2 1 3 00000022 0
0 3 1 0 00000033 0
0 4 1 2 00000044 0
1 0 3 2 050 0
1 1 0 1 061 0
1 2 1 3 072 0
1 3 1 1 083 0
1 4 1 2 094 0
2 0 2 0 1111222233334440 0
2 1 0 3 5555666677778881 0
2 2 1 3 99990000aaaabbb2 0
2 3 1 0 ccccddddeeeeff03 0
2 4 1 2 0123456789abcde4 0
0 0 3 1 00000100 12
0 0 3 0 00000108 0
0 0 2 3 00000110 0
0 0 3 3 00000118 0
0 0 0 0 00000200 8
0 1 0 1 00000201 0
0 2 0 3 00000202 0
0 3 0 2 00000203 0
0 4 0 0 00000204 0
0 1 0 2 00000209 0
0 2 0 1 0000020a 0

// ==== filelist.f ====
hw/noc_pkg.sv
hw/flit_fifo.sv
hw/rr_arbiter.sv
hw/mesh_router.sv
hw/nw_router.sv
dv/tb_nw_router.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the node router testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_nw_router -f filelist.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Simulation finished: PASS$" sim.log; then
  echo "Test passed"
  exit 0
else
  echo "Test failed"
  exit 1
fi
